//--- src/visor_reg_pkg.sv
package visor_reg_pkg;

    localparam int REG_IDX_WIDTH = 5;
    localparam int REG_COUNT     = 17;

    // writable registers
    localparam int REG_BP0          = 0;
    localparam int REG_BP1          = 1;
    localparam int REG_BP2          = 2;
    localparam int REG_BP3          = 3;
    localparam int REG_FORCE_OPCODE = 4;
    localparam int REG_POKE_DATA    = 5;
    localparam int REG_AV_WRITEDATA = 6;
    localparam int REG_AV_ADDRESS   = 7;
    localparam int REG_BUS_CTRL     = 8;
    localparam int REG_DEBUG_FORCE  = 9;
    localparam int REG_AV_CTRL      = 10;

    // read-only registers
    localparam int REG_EXR_SHADOW   = 11;
    localparam int REG_TG_CODE_ADDR = 12;
    localparam int REG_TG_PEEK      = 13;
    localparam int REG_TG_DEBUG_OUT = 14;
    localparam int REG_BP_HIT       = 15;
    localparam int REG_AV_STATUS    = 16;

    // bus control fields, bp enables are four bits from BUS_CTRL_BP_ENABLE up
    localparam int BUS_CTRL_FORCE_READY = 0;
    localparam int BUS_CTRL_RESET_REQ   = 1;
    localparam int BUS_CTRL_DIVERT      = 2;
    localparam int BUS_CTRL_BP_ENABLE   = 3;
    localparam int BUS_CTRL_WIDTH       = 7;

    localparam int AV_CTRL_START  = 0;
    localparam int AV_STATUS_BUSY = 0;

endpackage

//--- src/target_if_pkg.sv
package target_if_pkg;

    // code and data word of the target
    localparam int CODE_WIDTH = 16;

    // debug inputs are {force exec, force load exr, hold}
    localparam int DEBUG_IN_WIDTH = 3;

    localparam int DEBUG_OUT_WIDTH = 2;

    // debug output bits
    localparam int DBG_OUT_ENABLE_EXEC = 0;
    localparam int DBG_OUT_LOADING_EXR = 1;

endpackage

//--- src/visor_cmd_decoder.sv
module visor_cmd_decoder (
    input  logic                                    sysreset,
    input  logic                                    sysclk,
    input  logic                                    cmd_strobe,
    input  logic                                    cmd_write,
    input  logic [visor_reg_pkg::REG_IDX_WIDTH-1:0] cmd_reg,
    input  logic [target_if_pkg::CODE_WIDTH-1:0]    cmd_wdata,
    output logic [visor_reg_pkg::REG_COUNT-1:0]     reg_load,
    output logic [target_if_pkg::CODE_WIDTH-1:0]    load_data,
    output logic                                    rd_strobe,
    output logic [visor_reg_pkg::REG_IDX_WIDTH-1:0] rd_sel
);
    import visor_reg_pkg::*;

    logic writable;

    // read-only indices never get a strobe
    assign writable = (cmd_reg <= REG_IDX_WIDTH'(REG_AV_CTRL));

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            reg_load  <= '0;
            rd_strobe <= 1'b0;
        end else begin
            if (cmd_strobe && cmd_write && writable) begin
                reg_load <= REG_COUNT'(1) << cmd_reg;
            end else begin
                reg_load <= '0;
            end
            rd_strobe <= cmd_strobe && !cmd_write;
        end
    end

    // command payload
    always_ff @(posedge sysreset) begin
        if (cmd_strobe) begin
            load_data <= cmd_wdata;
            rd_sel    <= cmd_reg;
        end
    end

    // a single register per command
    a_load_onehot: assert property (
        @(posedge sysreset) disable iff (sysclk) $onehot0(reg_load)
    );

endmodule

//--- src/visor_reg_bank.sv
module visor_reg_bank #(
    parameter int NUM_BREAKPOINTS = 4
) (
    input  logic                                         sysreset,
    input  logic                                         sysclk,
    input  logic [visor_reg_pkg::REG_COUNT-1:0]          reg_load,
    input  logic [target_if_pkg::CODE_WIDTH-1:0]         load_data,
    input  logic                                         rd_strobe,
    input  logic [visor_reg_pkg::REG_IDX_WIDTH-1:0]      rd_sel,
    input  logic [target_if_pkg::CODE_WIDTH-1:0]         exr_shadow,
    input  logic                                         bp_hit,
    input  logic                                         av_busy,
    input  logic [target_if_pkg::CODE_WIDTH-1:0]         tg_code_addr,
    input  logic [target_if_pkg::CODE_WIDTH-1:0]         tg_peek_data,
    input  logic [target_if_pkg::DEBUG_OUT_WIDTH-1:0]    tg_debug_out,
    output logic [target_if_pkg::CODE_WIDTH-1:0]         bp_addr [4],
    output logic [3:0]                                   bp_enable,
    output logic                                         bp_clear,
    output logic [target_if_pkg::CODE_WIDTH-1:0]         force_opcode,
    output logic                                         divert,
    output logic                                         force_ready,
    output logic                                         reset_req,
    output logic [target_if_pkg::DEBUG_IN_WIDTH-1:0]     tg_debug_in,
    output logic [target_if_pkg::CODE_WIDTH-1:0]         tg_poke_data,
    output logic [target_if_pkg::CODE_WIDTH-1:0]         av_address,
    output logic [target_if_pkg::CODE_WIDTH-1:0]         av_writedata,
    output logic                                         av_start,
    output logic                                         rsp_strobe,
    output logic [target_if_pkg::CODE_WIDTH-1:0]         rsp_data
);
    import visor_reg_pkg::*;
    import target_if_pkg::*;

    logic [BUS_CTRL_WIDTH-1:0] bus_ctrl;
    logic [3:0]                bp_en_field;
    logic                      av_ctrl;

    assign bp_en_field = bus_ctrl[BUS_CTRL_BP_ENABLE +: 4];

    // slots past NUM_BREAKPOINTS read as zero and stay disabled
    for (genvar i = 0; i < 4; i++) begin : g_bp
        if (i < NUM_BREAKPOINTS) begin : g_used
            always_ff @(posedge sysreset or posedge sysclk) begin
                if (sysclk) begin
                    bp_addr[i] <= '0;
                end else if (reg_load[REG_BP0 + i]) begin
                    bp_addr[i] <= load_data;
                end
            end
            assign bp_enable[i] = bp_en_field[i];
        end else begin : g_unused
            assign bp_addr[i]   = '0;
            assign bp_enable[i] = 1'b0;
        end
    end

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            force_opcode <= '0;
            tg_poke_data <= '0;
            av_writedata <= '0;
            av_address   <= '0;
            bus_ctrl     <= '0;
            tg_debug_in  <= '0;
            av_ctrl      <= 1'b0;
        end else begin
            if (reg_load[REG_FORCE_OPCODE]) begin
                force_opcode <= load_data;
            end
            if (reg_load[REG_POKE_DATA]) begin
                tg_poke_data <= load_data;
            end
            if (reg_load[REG_AV_WRITEDATA]) begin
                av_writedata <= load_data;
            end
            if (reg_load[REG_AV_ADDRESS]) begin
                av_address <= load_data;
            end
            if (reg_load[REG_BUS_CTRL]) begin
                bus_ctrl <= load_data[BUS_CTRL_WIDTH-1:0];
            end
            if (reg_load[REG_DEBUG_FORCE]) begin
                tg_debug_in <= load_data[DEBUG_IN_WIDTH-1:0];
            end
            if (reg_load[REG_AV_CTRL]) begin
                av_ctrl <= load_data[AV_CTRL_START];
            end
        end
    end

    assign force_ready = bus_ctrl[BUS_CTRL_FORCE_READY];
    assign reset_req   = bus_ctrl[BUS_CTRL_RESET_REQ];
    assign divert      = bus_ctrl[BUS_CTRL_DIVERT];

    // one-cycle pulses, valid in the same cycle as the load
    assign bp_clear = |reg_load[REG_BP3:REG_BP0];
    assign av_start = reg_load[REG_AV_CTRL] && load_data[AV_CTRL_START];

    // registered readback
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            rsp_strobe <= 1'b0;
            rsp_data   <= '0;
        end else begin
            rsp_strobe <= rd_strobe;
            if (rd_strobe) begin
                rsp_data <= '0;
                case (rd_sel)
                    REG_BP0, REG_BP1, REG_BP2, REG_BP3: rsp_data <= bp_addr[rd_sel[1:0]];
                    REG_FORCE_OPCODE: rsp_data <= force_opcode;
                    REG_POKE_DATA:    rsp_data <= tg_poke_data;
                    REG_AV_WRITEDATA: rsp_data <= av_writedata;
                    REG_AV_ADDRESS:   rsp_data <= av_address;
                    REG_BUS_CTRL:     rsp_data <= CODE_WIDTH'(bus_ctrl);
                    REG_DEBUG_FORCE:  rsp_data <= CODE_WIDTH'(tg_debug_in);
                    REG_AV_CTRL:      rsp_data[AV_CTRL_START] <= av_ctrl;
                    REG_EXR_SHADOW:   rsp_data <= exr_shadow;
                    REG_TG_CODE_ADDR: rsp_data <= tg_code_addr;
                    REG_TG_PEEK:      rsp_data <= tg_peek_data;
                    REG_TG_DEBUG_OUT: rsp_data <= CODE_WIDTH'(tg_debug_out);
                    REG_BP_HIT:       rsp_data <= CODE_WIDTH'(bp_hit);
                    REG_AV_STATUS:    rsp_data[AV_STATUS_BUSY] <= av_busy;
                    default:          rsp_data <= '0;
                endcase
            end
        end
    end

endmodule

//--- src/breakpoint_unit.sv
module breakpoint_unit #(
    parameter int NUM_BREAKPOINTS = 4
) (
    input  logic                                      sysreset,
    input  logic                                      sysclk,
    input  logic [target_if_pkg::CODE_WIDTH-1:0]      tg_code_addr,
    input  logic [target_if_pkg::DEBUG_OUT_WIDTH-1:0] tg_debug_out,
    input  logic [target_if_pkg::CODE_WIDTH-1:0]      bp_addr [4],
    input  logic [3:0]                                bp_enable,
    input  logic                                      bp_clear,
    input  logic                                      divert,
    input  logic [target_if_pkg::CODE_WIDTH-1:0]      rom_code_in,
    output logic                                      bp_hit,
    output logic [target_if_pkg::CODE_WIDTH-1:0]      exr_shadow
);
    import target_if_pkg::*;

    logic match;
    logic enable_exec;
    logic loading_exr;

    assign enable_exec = tg_debug_out[DBG_OUT_ENABLE_EXEC];
    assign loading_exr = tg_debug_out[DBG_OUT_LOADING_EXR];

    // any enabled slot equal to the fetch address
    always_comb begin
        match = 1'b0;
        for (int i = 0; i < NUM_BREAKPOINTS; i++) begin
            if (bp_enable[i] && (tg_code_addr == bp_addr[i])) begin
                match = 1'b1;
            end
        end
    end

    // sticky until a breakpoint register is rewritten
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            bp_hit <= 1'b0;
        end else if (bp_clear) begin
            bp_hit <= 1'b0;
        end else if (match && enable_exec) begin
            bp_hit <= 1'b1;
        end
    end

    // shadow only what the real ROM delivers
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            exr_shadow <= '0;
        end else if (loading_exr && !divert) begin
            exr_shadow <= rom_code_in;
        end
    end

endmodule

//--- src/code_bus_diverter.sv
module code_bus_diverter (
    input  logic                                 sysclk,
    input  logic [target_if_pkg::CODE_WIDTH-1:0] rom_code_in,
    input  logic                                 rom_code_ready,
    input  logic [target_if_pkg::CODE_WIDTH-1:0] force_opcode,
    input  logic                                 divert,
    input  logic                                 force_ready,
    input  logic                                 reset_req,
    input  logic                                 bp_hit,
    output logic [target_if_pkg::CODE_WIDTH-1:0] tg_code_in,
    output logic                                 tg_code_ready,
    output logic                                 tg_reset
);

    // forced opcode path or the ROM
    assign tg_code_in = divert ? force_opcode : rom_code_in;

    // a breakpoint hit stalls the ROM path only
    assign tg_code_ready = divert ? force_ready : (rom_code_ready && !bp_hit);

    // target is held while the system is in reset
    assign tg_reset = sysclk || reset_req;

endmodule

//--- src/avalon_write_master.sv
module avalon_write_master (
    input  logic sysreset,
    input  logic sysclk,
    input  logic av_start,
    input  logic av_waitrequest,
    output logic av_write,
    output logic av_busy
);

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            av_write <= 1'b0;
        end else if (av_write) begin
            // slave accepted this cycle
            if (!av_waitrequest) begin
                av_write <= 1'b0;
            end
        end else if (av_start) begin
            av_write <= 1'b1;
        end
    end

    assign av_busy = av_write;

    // write must not be withdrawn while the slave stalls
    a_hold_write: assert property (
        @(posedge sysreset) disable iff (sysclk)
        av_write && av_waitrequest |=> av_write
    );

endmodule

//--- src/visor_top.sv
module visor_top #(
    parameter int NUM_BREAKPOINTS = 4
) (
    input  logic                                      sysreset,
    input  logic                                      sysclk,
    input  logic                                      cmd_strobe,
    input  logic                                      cmd_write,
    input  logic [visor_reg_pkg::REG_IDX_WIDTH-1:0]   cmd_reg,
    input  logic [target_if_pkg::CODE_WIDTH-1:0]      cmd_wdata,
    output logic                                      rsp_strobe,
    output logic [target_if_pkg::CODE_WIDTH-1:0]      rsp_data,
    input  logic [target_if_pkg::CODE_WIDTH-1:0]      rom_code_in,
    input  logic                                      rom_code_ready,
    input  logic [target_if_pkg::CODE_WIDTH-1:0]      tg_code_addr,
    output logic [target_if_pkg::CODE_WIDTH-1:0]      tg_code_in,
    output logic                                      tg_code_ready,
    output logic [target_if_pkg::DEBUG_IN_WIDTH-1:0]  tg_debug_in,
    input  logic [target_if_pkg::DEBUG_OUT_WIDTH-1:0] tg_debug_out,
    output logic                                      tg_reset,
    input  logic [target_if_pkg::CODE_WIDTH-1:0]      tg_peek_data,
    output logic [target_if_pkg::CODE_WIDTH-1:0]      tg_poke_data,
    output logic [target_if_pkg::CODE_WIDTH-1:0]      av_address,
    input  logic                                      av_waitrequest,
    output logic [target_if_pkg::CODE_WIDTH-1:0]      av_writedata,
    output logic                                      av_write
);
    import visor_reg_pkg::*;
    import target_if_pkg::*;

    // stage 1 to stage 2
    logic [REG_COUNT-1:0]     reg_load;
    logic [CODE_WIDTH-1:0]    load_data;
    logic                     rd_strobe;
    logic [REG_IDX_WIDTH-1:0] rd_sel;

    // bank controls
    logic [CODE_WIDTH-1:0] bp_addr [4];
    logic [3:0]            bp_enable;
    logic                  bp_clear;
    logic [CODE_WIDTH-1:0] force_opcode;
    logic                  divert;
    logic                  force_ready;
    logic                  reset_req;
    logic                  av_start;

    // status back into the bank
    logic [CODE_WIDTH-1:0] exr_shadow;
    logic                  bp_hit;
    logic                  av_busy;

    visor_cmd_decoder u_decoder (
        .sysreset   (sysreset),
        .sysclk     (sysclk),
        .cmd_strobe (cmd_strobe),
        .cmd_write  (cmd_write),
        .cmd_reg    (cmd_reg),
        .cmd_wdata  (cmd_wdata),
        .reg_load   (reg_load),
        .load_data  (load_data),
        .rd_strobe  (rd_strobe),
        .rd_sel     (rd_sel)
    );

    visor_reg_bank #(
        .NUM_BREAKPOINTS (NUM_BREAKPOINTS)
    ) u_bank (
        .sysreset     (sysreset),
        .sysclk       (sysclk),
        .reg_load     (reg_load),
        .load_data    (load_data),
        .rd_strobe    (rd_strobe),
        .rd_sel       (rd_sel),
        .exr_shadow   (exr_shadow),
        .bp_hit       (bp_hit),
        .av_busy      (av_busy),
        .tg_code_addr (tg_code_addr),
        .tg_peek_data (tg_peek_data),
        .tg_debug_out (tg_debug_out),
        .bp_addr      (bp_addr),
        .bp_enable    (bp_enable),
        .bp_clear     (bp_clear),
        .force_opcode (force_opcode),
        .divert       (divert),
        .force_ready  (force_ready),
        .reset_req    (reset_req),
        .tg_debug_in  (tg_debug_in),
        .tg_poke_data (tg_poke_data),
        .av_address   (av_address),
        .av_writedata (av_writedata),
        .av_start     (av_start),
        .rsp_strobe   (rsp_strobe),
        .rsp_data     (rsp_data)
    );

    breakpoint_unit #(
        .NUM_BREAKPOINTS (NUM_BREAKPOINTS)
    ) u_breakpoint (
        .sysreset     (sysreset),
        .sysclk       (sysclk),
        .tg_code_addr (tg_code_addr),
        .tg_debug_out (tg_debug_out),
        .bp_addr      (bp_addr),
        .bp_enable    (bp_enable),
        .bp_clear     (bp_clear),
        .divert       (divert),
        .rom_code_in  (rom_code_in),
        .bp_hit       (bp_hit),
        .exr_shadow   (exr_shadow)
    );

    code_bus_diverter u_diverter (
        .sysclk         (sysclk),
        .rom_code_in    (rom_code_in),
        .rom_code_ready (rom_code_ready),
        .force_opcode   (force_opcode),
        .divert         (divert),
        .force_ready    (force_ready),
        .reset_req      (reset_req),
        .bp_hit         (bp_hit),
        .tg_code_in     (tg_code_in),
        .tg_code_ready  (tg_code_ready),
        .tg_reset       (tg_reset)
    );

    avalon_write_master u_av_master (
        .sysreset       (sysreset),
        .sysclk         (sysclk),
        .av_start       (av_start),
        .av_waitrequest (av_waitrequest),
        .av_write       (av_write),
        .av_busy        (av_busy)
    );

endmodule

//--- verification/visor_tb.sv
module visor_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import visor_reg_pkg::*;
    import target_if_pkg::*;

    localparam int MAX_VECTORS = 256;

    // sysreset is the clock, sysclk the active high reset
    logic                       sysreset;
    logic                       sysclk;
    logic                       cmd_strobe;
    logic                       cmd_write;
    logic [REG_IDX_WIDTH-1:0]   cmd_reg;
    logic [CODE_WIDTH-1:0]      cmd_wdata;
    logic                       rsp_strobe;
    logic [CODE_WIDTH-1:0]      rsp_data;
    logic [CODE_WIDTH-1:0]      rom_code_in;
    logic                       rom_code_ready;
    logic [CODE_WIDTH-1:0]      tg_code_addr;
    logic [CODE_WIDTH-1:0]      tg_code_in;
    logic                       tg_code_ready;
    logic [DEBUG_IN_WIDTH-1:0]  tg_debug_in;
    logic [DEBUG_OUT_WIDTH-1:0] tg_debug_out;
    logic                       tg_reset;
    logic [CODE_WIDTH-1:0]      tg_peek_data;
    logic [CODE_WIDTH-1:0]      tg_poke_data;
    logic [CODE_WIDTH-1:0]      av_address;
    logic                       av_waitrequest;
    logic [CODE_WIDTH-1:0]      av_writedata;
    logic                       av_write;

    logic [7:0]  vec_op     [MAX_VECTORS];
    logic [15:0] vec_field  [MAX_VECTORS];
    logic [15:0] vec_value  [MAX_VECTORS];
    logic [15:0] vec_expect [MAX_VECTORS];
    int          num_vectors;

    int          cycle = 0;
    int          limit = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          test_id = 0;
    int          tests_done = 0;
    int          write_count = 0;
    int          stall_left = 0;
    logic        rom_fixed = 1'b0;
    logic        stalled_before = 1'b0;
    logic [15:0] last_addr;
    logic [15:0] last_data;

    // reads in flight with due cycle, expected data and register index
    int          due_q [$];
    logic [15:0] exp_q [$];
    int          reg_q [$];

    visor_top #(
        .NUM_BREAKPOINTS (4)
    ) i_dut (.*);

    initial begin
        sysreset = 1'b0;
        forever #4 sysreset = ~sysreset;
    end

    always @(posedge sysreset) cycle++;

    initial begin
        wait (limit > 0);
        while (cycle < limit) @(posedge sysreset);
        $display("timeout: vectors did not finish within %0d cycles", limit);
        $display("Regression failed");
        $finish;
    end

    task automatic report_error(input string msg);
        errors++;
        test_errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    // random ROM background and the Avalon slave's waitrequest
    always @(posedge sysreset) begin
        #1;
        if (!rom_fixed) begin
            rom_code_in = 16'($urandom);
        end
        if (!av_write) begin
            av_waitrequest = 1'b1;
            stall_left = $urandom_range(5, 0);
        end else if (stall_left > 0) begin
            av_waitrequest = 1'b1;
            stall_left--;
        end else begin
            av_waitrequest = 1'b0;
        end
    end

    // mid-cycle sampling of accepted writes and read responses
    always @(negedge sysreset) begin : response_monitor
        int          due;
        int          idx;
        logic [15:0] exp_data;

        if (stalled_before && !av_write) begin
            report_error("av_write dropped while waitrequest was high");
        end
        stalled_before = av_write && av_waitrequest;
        if (av_write && !av_waitrequest) begin
            write_count++;
            last_addr = av_address;
            last_data = av_writedata;
        end
        if (rsp_strobe) begin
            if (due_q.size() == 0) begin
                report_error("rsp_strobe came without a pending read");
            end else begin
                due = due_q.pop_front();
                exp_data = exp_q.pop_front();
                idx = reg_q.pop_front();
                if (due != cycle) begin
                    report_error($sformatf("read of register %0d answered in cycle %0d, not %0d",
                                           idx, cycle, due));
                end
                check_value($sformatf("rsp_data(reg %0d)", idx), exp_data, rsp_data);
            end
        end else if (due_q.size() > 0 && due_q[0] <= cycle) begin
            report_error($sformatf("no response to the read of register %0d", reg_q[0]));
            void'(due_q.pop_front());
            void'(exp_q.pop_front());
            void'(reg_q.pop_front());
        end
    end

    task automatic next_cycle;
        @(posedge sysreset);
        #1;
    endtask

    task automatic send_command(input logic write, input logic [4:0] idx,
                                input logic [15:0] data);
        cmd_strobe = 1'b1;
        cmd_write  = write;
        cmd_reg    = idx;
        cmd_wdata  = data;
        next_cycle();
        cmd_strobe = 1'b0;
    endtask

    task automatic send_read(input logic [4:0] idx, input logic [15:0] expected);
        due_q.push_back(cycle + 2);
        exp_q.push_back(expected);
        reg_q.push_back(idx);
        send_command(1'b0, idx, 16'h0000);
    endtask

    task automatic set_target_input(input logic [15:0] field, input logic [15:0] value);
        case (field)
            0: tg_code_addr = value;
            1: tg_peek_data = value;
            2: tg_debug_out = value[DEBUG_OUT_WIDTH-1:0];
            3: rom_code_ready = value[0];
            4: begin
                rom_fixed = 1'b1;
                rom_code_in = value;
            end
            5: rom_fixed = 1'b0;
            default: report_error($sformatf("unknown input field %0d in vectors", field));
        endcase
    endtask

    task automatic check_output(input logic [15:0] field, input logic [15:0] expected);
        @(negedge sysreset);
        case (field)
            0: check_value("tg_code_in", expected, tg_code_in);
            1: check_value("tg_code_ready", expected, tg_code_ready);
            2: check_value("tg_reset", expected, tg_reset);
            3: check_value("tg_debug_in", expected, tg_debug_in);
            4: check_value("tg_poke_data", expected, tg_poke_data);
            // ROM path against the word driven right now
            5: check_value("tg_code_in", rom_code_in, tg_code_in);
            default: report_error($sformatf("unknown output field %0d in vectors", field));
        endcase
        next_cycle();
    endtask

    // variant 0 reads the status while busy and variant 1 sends a second start
    task automatic run_avalon_write(input logic [15:0] variant, input logic [15:0] exp_addr,
                                    input logic [15:0] exp_data);
        int count_before;

        count_before = write_count;
        send_command(1'b1, REG_AV_CTRL, 16'h0001);
        if (variant == 0) begin
            send_read(REG_AV_STATUS, 16'h0001);
        end else begin
            send_command(1'b1, REG_AV_CTRL, 16'h0001);
        end
        check_value("av_write", 16'h0001, av_write);
        while (av_write === 1'b1) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        check_value("av_write", 16'h0000, av_write);
        check_value("write count", 16'h0001, 16'(write_count - count_before));
        check_value("av_address", exp_addr, last_addr);
        check_value("av_writedata", exp_data, last_data);
        send_read(REG_AV_STATUS, 16'h0000);
    endtask

    task automatic finish_test;
        while (due_q.size() > 0) begin
            next_cycle();
        end
        $display("test %0d finished: %0d errors", test_id, test_errors);
        tests_done++;
        test_errors = 0;
    endtask

    initial begin : main
        int               fd;
        int               code;
        int               n;
        logic [8*120-1:0] line_buf;
        logic [7:0]       op;
        logic [15:0]      field;
        logic [15:0]      value;
        logic [15:0]      exp_val;

        void'($urandom(56));
        sysclk = 1'b1;
        cmd_strobe = 1'b0;
        cmd_write = 1'b0;
        cmd_reg = '0;
        cmd_wdata = '0;
        rom_code_in = '0;
        rom_code_ready = 1'b0;
        tg_code_addr = '0;
        tg_debug_out = '0;
        tg_peek_data = '0;
        av_waitrequest = 1'b1;

        num_vectors = 0;
        fd = $fopen("verification/visor_vectors.txt", "r");
        if (fd == 0) begin
            report_error("cannot open verification/visor_vectors.txt");
        end else begin
            while (!$feof(fd) && num_vectors < MAX_VECTORS) begin
                line_buf = '0;
                code = $fgets(line_buf, fd);
                if (code > 0) begin
                    code = $sscanf(line_buf, "%s %h %h %h", op, field, value, exp_val);
                    // comment lines and blank lines fall out here
                    if (code == 4 && op != "#") begin
                        vec_op[num_vectors] = op;
                        vec_field[num_vectors] = field;
                        vec_value[num_vectors] = value;
                        vec_expect[num_vectors] = exp_val;
                        num_vectors++;
                    end
                end
            end
            $fclose(fd);
        end
        limit = 20 * num_vectors + 100;

        repeat (2) @(posedge sysreset);
        #1;
        check_value("tg_reset", 16'h0001, tg_reset);
        check_value("rsp_strobe", 16'h0000, rsp_strobe);
        check_value("av_write", 16'h0000, av_write);
        sysclk = 1'b0;
        next_cycle();

        for (n = 0; n < num_vectors; n++) begin
            case (vec_op[n])
                "t": begin
                    finish_test();
                    test_id = vec_field[n];
                end
                "w": send_command(1'b1, vec_field[n][4:0], vec_value[n]);
                "r": send_read(vec_field[n][4:0], vec_expect[n]);
                "s": set_target_input(vec_field[n], vec_value[n]);
                "c": check_output(vec_field[n], vec_expect[n]);
                "i": repeat (vec_value[n]) next_cycle();
                "a": run_avalon_write(vec_field[n], vec_value[n], vec_expect[n]);
                default: report_error($sformatf("unknown op in vector line %0d", n));
            endcase
        end
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- verification/visor_vectors.txt
# op field value expected, hex; t test, w write, r read-expect, s set input,
# c check output, i idle cycles, a avalon write (value address, expected data)
t 1 0 0
w 00 1234 0
w 01 2345 0
w 02 3456 0
w 03 4567 0
w 04 a5a5 0
w 05 5a5a 0
w 06 0f0f 0
w 07 00f0 0
w 09 0005 0
w 0b ffff 0
w 10 0001 0
r 00 0 1234
r 01 0 2345
r 02 0 3456
r 03 0 4567
r 04 0 a5a5
r 05 0 5a5a
r 06 0 0f0f
r 07 0 00f0
r 09 0 0005
r 0b 0 0000
r 10 0 0000
t 2 0 0
s 00 0200 0
s 02 0001 0
s 03 0001 0
w 00 0100 0
w 08 0008 0
i 0 0002 0
r 0f 0 0000
s 00 0100 0
i 0 0001 0
c 01 0 0000
r 0f 0 0001
w 01 0300 0
s 00 0300 0
i 0 0003 0
r 0f 0 0000
c 01 0 0001
w 08 0000 0
s 02 0000 0
t 3 0 0
w 08 0005 0
i 0 0001 0
c 00 0 a5a5
c 01 0 0001
r 08 0 0005
w 08 0004 0
i 0 0001 0
c 01 0 0000
w 08 0000 0
i 0 0001 0
c 05 0 0000
c 01 0 0001
t 4 0 0
c 02 0 0000
w 08 0002 0
i 0 0001 0
c 02 0 0001
w 08 0000 0
i 0 0001 0
c 02 0 0000
c 03 0 0005
c 04 0 5a5a
t 5 0 0
s 04 beef 0
s 02 0002 0
i 0 0002 0
s 02 0000 0
r 0b 0 beef
w 08 0004 0
i 0 0001 0
s 04 1234 0
s 02 0002 0
i 0 0002 0
s 02 0000 0
w 08 0000 0
r 0b 0 beef
s 05 0 0
s 00 4321 0
s 01 8765 0
s 02 0003 0
r 0c 0 4321
r 0d 0 8765
r 0e 0 0003
i 0 0002 0
s 02 0000 0
t 6 0 0
w 07 0040 0
w 06 cafe 0
a 00 0040 cafe
a 01 0040 cafe
r 0a 0 0001

//--- visor_top.f
src/visor_reg_pkg.sv
src/target_if_pkg.sv
src/visor_cmd_decoder.sv
src/visor_reg_bank.sv
src/breakpoint_unit.sv
src/code_bus_diverter.sv
src/avalon_write_master.sv
src/visor_top.sv
verification/visor_tb.sv

//--- Bender.yml
package:
  name: visor

sources:
  # packages first, then the RTL bottom up
  - src/visor_reg_pkg.sv
  - src/target_if_pkg.sv
  - src/visor_cmd_decoder.sv
  - src/visor_reg_bank.sv
  - src/breakpoint_unit.sv
  - src/code_bus_diverter.sv
  - src/avalon_write_master.sv
  - src/visor_top.sv
  - target: test
    files:
      - verification/visor_tb.sv
